// ==== verilog/cpuPkg.sv ====
/* sizes and encodings for the straight-line RV32I subset: OP, OP-IMM, LUI, SB and SW
   only, tags are reservation-entry indices */
package cpuPkg;
    localparam int xlen = 32;
    localparam int regCount = 32;
    localparam int regNameWidth = 5;
    localparam int rsCount = 4;
    localparam int tagWidth = 2;
    localparam int aluOpWidth = 4;

    // alu operation codes, passB carries the LUI immediate
    localparam logic [aluOpWidth-1:0] aluAdd = 4'd0;
    localparam logic [aluOpWidth-1:0] aluSub = 4'd1;
    localparam logic [aluOpWidth-1:0] aluSll = 4'd2;
    localparam logic [aluOpWidth-1:0] aluSlt = 4'd3;
    localparam logic [aluOpWidth-1:0] aluSltu = 4'd4;
    localparam logic [aluOpWidth-1:0] aluXor = 4'd5;
    localparam logic [aluOpWidth-1:0] aluSrl = 4'd6;
    localparam logic [aluOpWidth-1:0] aluSra = 4'd7;
    localparam logic [aluOpWidth-1:0] aluOr = 4'd8;
    localparam logic [aluOpWidth-1:0] aluAnd = 4'd9;
    localparam logic [aluOpWidth-1:0] aluPassB = 4'd10;

    localparam logic [6:0] opOp = 7'b0110011;
    localparam logic [6:0] opOpImm = 7'b0010011;
    localparam logic [6:0] opLui = 7'b0110111;
    localparam logic [6:0] opStore = 7'b0100011;

    // store width in funct3
    localparam logic [2:0] f3Byte = 3'b000;
    localparam logic [2:0] f3Word = 3'b010;

    // bits 17:16 set select I/O, +4 is the end marker
    localparam logic [xlen-1:0] ioBase = 32'h0003_0000;

    // memory controller states
    localparam logic [1:0] mcFetch = 2'd0;
    localparam logic [1:0] mcHold = 2'd1;
    localparam logic [1:0] mcStore = 2'd2;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rFields;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } iFields;

    typedef struct packed {
        logic [6:0] immHi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] immLo;
        logic [6:0] opcode;
    } sFields;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0] rd;
        logic [6:0] opcode;
    } uFields;

    typedef union packed {
        rFields r;
        iFields i;
        sFields s;
        uFields u;
    } instWord;
endpackage

// ==== verilog/memCtrl.sv ====
/* byte-bus sequencer: reads return one cycle after the address, writes take one cycle;
   fetch and store never overlap, the word is held until the dispatcher takes it */
`timescale 1ns/10ps
module memCtrl (
    input  logic clk_in,
    input  logic rstN,
    input  logic rdy,
    input  logic [7:0] memDin,
    output logic [7:0] memDout,
    output logic [31:0] memA,
    output logic memWr,
    output logic instValid,
    output cpuPkg::instWord inst,
    output logic [31:0] instPc,
    input  logic instTaken,
    input  logic storeEn,
    input  logic [31:0] storeAddr,
    input  logic [31:0] storeData,
    input  logic storeWord,
    output logic storeBusy
);
    logic [1:0] state;
    logic [2:0] byteCnt;
    logic [31:0] pc, stAddr, stData;
    logic stWord, stLast;

    assign instPc = pc;
    assign storeBusy = state == cpuPkg::mcStore;
    assign stLast = stWord ? byteCnt == 3'd3 : byteCnt == 3'd0;
    // no write may reach the bus while the core is frozen
    assign memWr = storeBusy && rdy;
    assign memA = storeBusy ? stAddr + {29'b0, byteCnt} : pc + {29'b0, byteCnt};
    assign memDout = stData[8 * byteCnt[1:0] +: 8];

    always_ff @(posedge clk_in or negedge rstN) begin
        if (!rstN) begin
            state <= cpuPkg::mcFetch;
            byteCnt <= 3'd0;
            pc <= '0;
            instValid <= 1'b0;
        end else if (rdy) begin
            case (state)
                cpuPkg::mcFetch: begin
                    byteCnt <= byteCnt + 3'd1;
                    // count 4 sees the last byte on memDin
                    if (byteCnt == 3'd4) begin
                        state <= cpuPkg::mcHold;
                        instValid <= 1'b1;
                    end
                end
                cpuPkg::mcHold: begin
                    if (instTaken) begin
                        state <= storeEn ? cpuPkg::mcStore : cpuPkg::mcFetch;
                        byteCnt <= 3'd0;
                        pc <= pc + 32'd4;
                        instValid <= 1'b0;
                    end
                end
                cpuPkg::mcStore: begin
                    byteCnt <= stLast ? 3'd0 : byteCnt + 3'd1;
                    if (stLast) begin
                        state <= cpuPkg::mcFetch;
                    end
                end
                default: state <= cpuPkg::mcFetch;
            endcase
        end
    end

    always_ff @(posedge clk_in) begin
        if (rdy) begin
            // little-endian, each new byte enters at the top
            if (state == cpuPkg::mcFetch && byteCnt != 3'd0) begin
                inst <= {memDin, inst[31:8]};
            end
            if (storeEn) begin
                stAddr <= storeAddr;
                stData <= storeData;
                stWord <= storeWord;
            end
        end
    end

    // stores come only with the held instruction, never mid-fetch or mid-store
    assert property (@(posedge clk_in) disable iff (!rstN)
        storeEn |-> state == cpuPkg::mcHold && instTaken);
endmodule

// ==== verilog/dispatcher.sv ====
/* one instruction per cycle into the lowest free entry, with same-cycle bus forwarding;
   stores wait until no entry and no register is busy, unknown opcodes are dropped */
`timescale 1ns/10ps
module dispatcher (
    input  logic clk_in,
    input  logic rstN,
    input  logic rdy,
    input  logic instValid,
    input  cpuPkg::instWord inst,
    input  logic [cpuPkg::xlen-1:0] instPc,
    output logic instTaken,
    output logic [cpuPkg::regNameWidth-1:0] srcNameA,
    output logic [cpuPkg::regNameWidth-1:0] srcNameB,
    input  logic [cpuPkg::xlen-1:0] srcValA,
    input  logic [cpuPkg::xlen-1:0] srcValB,
    input  logic srcBusyA,
    input  logic srcBusyB,
    input  logic [cpuPkg::tagWidth-1:0] srcTagA,
    input  logic [cpuPkg::tagWidth-1:0] srcTagB,
    input  logic anyRegBusy,
    output logic renameEn,
    output logic [cpuPkg::regNameWidth-1:0] renameName,
    output logic [cpuPkg::tagWidth-1:0] renameTag,
    input  logic [cpuPkg::rsCount-1:0] rsBusy,
    output logic [cpuPkg::rsCount-1:0] allocEn,
    output logic [cpuPkg::aluOpWidth-1:0] allocOp,
    output logic [cpuPkg::xlen-1:0] allocValA,
    output logic [cpuPkg::xlen-1:0] allocValB,
    output logic allocPendA,
    output logic allocPendB,
    output logic [cpuPkg::tagWidth-1:0] allocTagA,
    output logic [cpuPkg::tagWidth-1:0] allocTagB,
    input  logic cdbValid,
    input  logic [cpuPkg::tagWidth-1:0] cdbTag,
    input  logic [cpuPkg::xlen-1:0] cdbData,
    output logic storeEn,
    output logic [cpuPkg::xlen-1:0] storeAddr,
    output logic [cpuPkg::xlen-1:0] storeData,
    output logic storeWord,
    input  logic storeBusy
);
    logic isOp, isOpImm, isLui, isStore, isAlu;
    logic freeFound, aluFire, storeFire, dropFire;
    logic hitA, hitB;
    logic [cpuPkg::tagWidth-1:0] freeIdx;
    logic [cpuPkg::xlen-1:0] immI, immS;

    assign isOp = inst.r.opcode == cpuPkg::opOp;
    assign isOpImm = inst.r.opcode == cpuPkg::opOpImm;
    assign isLui = inst.r.opcode == cpuPkg::opLui;
    assign isStore = inst.r.opcode == cpuPkg::opStore;
    assign isAlu = isOp || isOpImm || isLui;

    assign srcNameA = inst.r.rs1;
    assign srcNameB = inst.r.rs2;
    assign immI = {{20{inst.i.imm[11]}}, inst.i.imm};
    assign immS = {{20{inst.s.immHi[6]}}, inst.s.immHi, inst.s.immLo};

    // result broadcast this very cycle
    assign hitA = srcBusyA && cdbValid && cdbTag == srcTagA;
    assign hitB = srcBusyB && cdbValid && cdbTag == srcTagB;

    always_comb begin
        freeFound = 1'b0;
        freeIdx = '0;
        for (int k = cpuPkg::rsCount - 1; k >= 0; k--) begin
            if (!rsBusy[k]) begin
                freeFound = 1'b1;
                freeIdx = k[cpuPkg::tagWidth-1:0];
            end
        end
    end

    assign aluFire = rdy && instValid && isAlu && freeFound;
    assign storeFire = rdy && instValid && isStore && rsBusy == '0 && !anyRegBusy
        && !storeBusy;
    assign dropFire = rdy && instValid && !isAlu && !isStore;
    assign instTaken = aluFire || storeFire || dropFire;

    always_comb begin
        allocEn = '0;
        if (aluFire) begin
            allocEn[freeIdx] = 1'b1;
        end
    end

    // srai and sub share bit 30
    always_comb begin
        case (inst.r.funct3)
            3'd0: allocOp = (isOp && inst.r.funct7[5]) ? cpuPkg::aluSub : cpuPkg::aluAdd;
            3'd1: allocOp = cpuPkg::aluSll;
            3'd2: allocOp = cpuPkg::aluSlt;
            3'd3: allocOp = cpuPkg::aluSltu;
            3'd4: allocOp = cpuPkg::aluXor;
            3'd5: allocOp = inst.r.funct7[5] ? cpuPkg::aluSra : cpuPkg::aluSrl;
            3'd6: allocOp = cpuPkg::aluOr;
            default: allocOp = cpuPkg::aluAnd;
        endcase
        if (isLui) begin
            allocOp = cpuPkg::aluPassB;
        end
    end

    assign allocTagA = srcTagA;
    assign allocTagB = srcTagB;
    assign allocValA = hitA ? cdbData : srcValA;
    // lui never reads A, its rs1 field is immediate bits
    assign allocPendA = srcBusyA && !hitA && !isLui;
    assign allocValB = isOp ? (hitB ? cdbData : srcValB)
        : isLui ? {inst.u.imm, 12'b0} : immI;
    assign allocPendB = isOp && srcBusyB && !hitB;

    assign renameEn = aluFire && inst.r.rd != '0;
    assign renameName = inst.r.rd;
    assign renameTag = freeIdx;

    assign storeEn = storeFire;
    assign storeAddr = srcValA + immS;
    assign storeData = srcValB;
    assign storeWord = inst.s.funct3 == cpuPkg::f3Word;

    // fetch only ever steps whole words
    assert property (@(posedge clk_in) disable iff (!rstN)
        instValid |-> instPc[1:0] == 2'b00);
endmodule

// ==== verilog/regFile.sv ====
/* 32 registers with busy flag and producer tag; reads are combinational, x0 reads zero
   since it is never renamed and so never written */
`timescale 1ns/10ps
module regFile (
    input  logic clk_in,
    input  logic rstN,
    input  logic rdy,
    input  logic [cpuPkg::regNameWidth-1:0] nameA,
    output logic [cpuPkg::xlen-1:0] valA,
    output logic busyA,
    output logic [cpuPkg::tagWidth-1:0] tagA,
    input  logic [cpuPkg::regNameWidth-1:0] nameB,
    output logic [cpuPkg::xlen-1:0] valB,
    output logic busyB,
    output logic [cpuPkg::tagWidth-1:0] tagB,
    output logic anyRegBusy,
    input  logic renameEn,
    input  logic [cpuPkg::regNameWidth-1:0] renameName,
    input  logic [cpuPkg::tagWidth-1:0] renameTag,
    input  logic cdbValid,
    input  logic [cpuPkg::tagWidth-1:0] cdbTag,
    input  logic [cpuPkg::xlen-1:0] cdbData
);
    logic [cpuPkg::xlen-1:0] regs [cpuPkg::regCount];
    logic [cpuPkg::tagWidth-1:0] tags [cpuPkg::regCount];
    logic [cpuPkg::regCount-1:0] busy;

    assign valA = regs[nameA];
    assign busyA = busy[nameA];
    assign tagA = tags[nameA];
    assign valB = regs[nameB];
    assign busyB = busy[nameB];
    assign tagB = tags[nameB];
    assign anyRegBusy = |busy;

    always_ff @(posedge clk_in or negedge rstN) begin
        if (!rstN) begin
            busy <= '0;
            for (int r = 0; r < cpuPkg::regCount; r++) begin
                regs[r] <= '0;
                tags[r] <= '0;
            end
        end else if (rdy) begin
            // only the latest producer of a register may retire into it
            for (int r = 1; r < cpuPkg::regCount; r++) begin
                if (cdbValid && busy[r] && tags[r] == cdbTag) begin
                    regs[r] <= cdbData;
                    busy[r] <= 1'b0;
                end
            end
            // a rename in the same cycle wins over the clear
            if (renameEn) begin
                busy[renameName] <= 1'b1;
                tags[renameName] <= renameTag;
            end
        end
    end

    assert property (@(posedge clk_in) disable iff (!rstN) !busy[0]);
endmodule

// ==== verilog/rsEntry.sv ====
/* one reservation entry; operands wait on a tag and are captured off the result bus,
   the entry frees at the edge after it issues */
`timescale 1ns/10ps
module rsEntry (
    input  logic clk_in,
    input  logic rstN,
    input  logic rdy,
    input  logic allocEn,
    input  logic [cpuPkg::aluOpWidth-1:0] allocOp,
    input  logic [cpuPkg::xlen-1:0] allocValA,
    input  logic [cpuPkg::xlen-1:0] allocValB,
    input  logic [cpuPkg::tagWidth-1:0] allocTagA,
    input  logic [cpuPkg::tagWidth-1:0] allocTagB,
    input  logic allocPendA,
    input  logic allocPendB,
    input  logic cdbValid,
    input  logic [cpuPkg::tagWidth-1:0] cdbTag,
    input  logic [cpuPkg::xlen-1:0] cdbData,
    input  logic issueEn,
    output logic busy,
    output logic ready,
    output logic [cpuPkg::aluOpWidth-1:0] op,
    output logic [cpuPkg::xlen-1:0] valA,
    output logic [cpuPkg::xlen-1:0] valB
);
    logic pendA, pendB, hitA, hitB;
    logic [cpuPkg::tagWidth-1:0] tagA, tagB;

    assign hitA = busy && pendA && cdbValid && cdbTag == tagA;
    assign hitB = busy && pendB && cdbValid && cdbTag == tagB;
    assign ready = busy && !pendA && !pendB;

    always_ff @(posedge clk_in or negedge rstN) begin
        if (!rstN) begin
            busy <= 1'b0;
            pendA <= 1'b0;
            pendB <= 1'b0;
        end else if (rdy) begin
            if (allocEn) begin
                busy <= 1'b1;
                pendA <= allocPendA;
                pendB <= allocPendB;
            end else begin
                if (issueEn) begin
                    busy <= 1'b0;
                end
                if (hitA) begin
                    pendA <= 1'b0;
                end
                if (hitB) begin
                    pendB <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (rdy) begin
            if (allocEn) begin
                op <= allocOp;
                valA <= allocValA;
                valB <= allocValB;
                tagA <= allocTagA;
                tagB <= allocTagB;
            end else begin
                if (hitA) begin
                    valA <= cdbData;
                end
                if (hitB) begin
                    valB <= cdbData;
                end
            end
        end
    end

    // the dispatcher must pick a free entry
    assert property (@(posedge clk_in) disable iff (!rstN) allocEn |-> !busy);
endmodule

// ==== verilog/aluIssue.sv ====
/* fixed priority, lowest ready entry first; one result per cycle, registered onto the
   common data bus with the entry index as its tag */
`timescale 1ns/10ps
module aluIssue (
    input  logic clk_in,
    input  logic rstN,
    input  logic rdy,
    input  logic [cpuPkg::rsCount-1:0] rsReady,
    input  logic [cpuPkg::aluOpWidth-1:0] entryOp [cpuPkg::rsCount],
    input  logic [cpuPkg::xlen-1:0] entryValA [cpuPkg::rsCount],
    input  logic [cpuPkg::xlen-1:0] entryValB [cpuPkg::rsCount],
    output logic [cpuPkg::rsCount-1:0] issueEn,
    output logic cdbValid,
    output logic [cpuPkg::tagWidth-1:0] cdbTag,
    output logic [cpuPkg::xlen-1:0] cdbData
);
    logic pickFound;
    logic [cpuPkg::tagWidth-1:0] pickIdx;
    logic [cpuPkg::xlen-1:0] opA, opB, result;
    logic [4:0] shamt;

    always_comb begin
        pickFound = 1'b0;
        pickIdx = '0;
        for (int k = cpuPkg::rsCount - 1; k >= 0; k--) begin
            if (rsReady[k]) begin
                pickFound = 1'b1;
                pickIdx = k[cpuPkg::tagWidth-1:0];
            end
        end
    end

    always_comb begin
        issueEn = '0;
        if (rdy && pickFound) begin
            issueEn[pickIdx] = 1'b1;
        end
    end

    assign opA = entryValA[pickIdx];
    assign opB = entryValB[pickIdx];
    assign shamt = opB[4:0];

    always_comb begin
        case (entryOp[pickIdx])
            cpuPkg::aluAdd: result = opA + opB;
            cpuPkg::aluSub: result = opA - opB;
            cpuPkg::aluSll: result = opA << shamt;
            cpuPkg::aluSlt: result = {31'b0, $signed(opA) < $signed(opB)};
            cpuPkg::aluSltu: result = {31'b0, opA < opB};
            cpuPkg::aluXor: result = opA ^ opB;
            cpuPkg::aluSrl: result = opA >> shamt;
            cpuPkg::aluSra: result = $unsigned($signed(opA) >>> shamt);
            cpuPkg::aluOr: result = opA | opB;
            cpuPkg::aluAnd: result = opA & opB;
            default: result = opB;
        endcase
    end

    always_ff @(posedge clk_in or negedge rstN) begin
        if (!rstN) begin
            cdbValid <= 1'b0;
        end else if (rdy) begin
            cdbValid <= pickFound;
        end
    end

    always_ff @(posedge clk_in) begin
        if (rdy && pickFound) begin
            cdbTag <= pickIdx;
            cdbData <= result;
        end
    end

    // an issued entry always holds a defined operation
    assert property (@(posedge clk_in) disable iff (!rstN)
        pickFound |-> entryOp[pickIdx] <= cpuPkg::aluPassB);
endmodule

// ==== verilog/cpu.sv ====
/* out-of-order RV32I subset core on the byte memory port; rdy low freezes all state,
   programs must be straight-line OP, OP-IMM, LUI, SB and SW */
`timescale 1ns/10ps
module cpu (
    input  logic clk_in,
    input  logic rstN,
    input  logic rdy,
    input  logic [7:0] memDin,
    output logic [7:0] memDout,
    output logic [31:0] memA,
    output logic memWr
);
    logic instValid, instTaken;
    cpuPkg::instWord inst;
    logic [cpuPkg::xlen-1:0] instPc;
    logic storeEn, storeWord, storeBusy;
    logic [cpuPkg::xlen-1:0] storeAddr, storeData;
    logic [cpuPkg::regNameWidth-1:0] srcNameA, srcNameB, renameName;
    logic [cpuPkg::xlen-1:0] srcValA, srcValB;
    logic srcBusyA, srcBusyB, anyRegBusy, renameEn;
    logic [cpuPkg::tagWidth-1:0] srcTagA, srcTagB, renameTag;
    logic [cpuPkg::rsCount-1:0] rsBusy, rsReady, allocEn, issueEn;
    logic [cpuPkg::aluOpWidth-1:0] allocOp;
    logic [cpuPkg::xlen-1:0] allocValA, allocValB;
    logic allocPendA, allocPendB;
    logic [cpuPkg::tagWidth-1:0] allocTagA, allocTagB;
    logic [cpuPkg::aluOpWidth-1:0] entryOp [cpuPkg::rsCount];
    logic [cpuPkg::xlen-1:0] entryValA [cpuPkg::rsCount];
    logic [cpuPkg::xlen-1:0] entryValB [cpuPkg::rsCount];
    // common data bus
    logic cdbValid;
    logic [cpuPkg::tagWidth-1:0] cdbTag;
    logic [cpuPkg::xlen-1:0] cdbData;

    memCtrl mcu (
        .clk_in(clk_in), .rstN(rstN), .rdy(rdy),
        .memDin(memDin), .memDout(memDout), .memA(memA), .memWr(memWr),
        .instValid(instValid), .inst(inst), .instPc(instPc), .instTaken(instTaken),
        .storeEn(storeEn), .storeAddr(storeAddr), .storeData(storeData),
        .storeWord(storeWord), .storeBusy(storeBusy)
    );

    dispatcher disp (
        .clk_in(clk_in), .rstN(rstN), .rdy(rdy),
        .instValid(instValid), .inst(inst), .instPc(instPc), .instTaken(instTaken),
        .srcNameA(srcNameA), .srcNameB(srcNameB), .srcValA(srcValA), .srcValB(srcValB),
        .srcBusyA(srcBusyA), .srcBusyB(srcBusyB), .srcTagA(srcTagA), .srcTagB(srcTagB),
        .anyRegBusy(anyRegBusy),
        .renameEn(renameEn), .renameName(renameName), .renameTag(renameTag),
        .rsBusy(rsBusy), .allocEn(allocEn), .allocOp(allocOp),
        .allocValA(allocValA), .allocValB(allocValB),
        .allocPendA(allocPendA), .allocPendB(allocPendB),
        .allocTagA(allocTagA), .allocTagB(allocTagB),
        .cdbValid(cdbValid), .cdbTag(cdbTag), .cdbData(cdbData),
        .storeEn(storeEn), .storeAddr(storeAddr), .storeData(storeData),
        .storeWord(storeWord), .storeBusy(storeBusy)
    );

    regFile regf (
        .clk_in(clk_in), .rstN(rstN), .rdy(rdy),
        .nameA(srcNameA), .valA(srcValA), .busyA(srcBusyA), .tagA(srcTagA),
        .nameB(srcNameB), .valB(srcValB), .busyB(srcBusyB), .tagB(srcTagB),
        .anyRegBusy(anyRegBusy),
        .renameEn(renameEn), .renameName(renameName), .renameTag(renameTag),
        .cdbValid(cdbValid), .cdbTag(cdbTag), .cdbData(cdbData)
    );

    for (genvar g = 0; g < cpuPkg::rsCount; g++) begin : rsBank
        rsEntry entry (
            .clk_in(clk_in), .rstN(rstN), .rdy(rdy),
            .allocEn(allocEn[g]), .allocOp(allocOp),
            .allocValA(allocValA), .allocValB(allocValB),
            .allocTagA(allocTagA), .allocTagB(allocTagB),
            .allocPendA(allocPendA), .allocPendB(allocPendB),
            .cdbValid(cdbValid), .cdbTag(cdbTag), .cdbData(cdbData),
            .issueEn(issueEn[g]), .busy(rsBusy[g]), .ready(rsReady[g]),
            .op(entryOp[g]), .valA(entryValA[g]), .valB(entryValB[g])
        );
    end

    aluIssue alu (
        .clk_in(clk_in), .rstN(rstN), .rdy(rdy),
        .rsReady(rsReady), .entryOp(entryOp), .entryValA(entryValA), .entryValB(entryValB),
        .issueEn(issueEn), .cdbValid(cdbValid), .cdbTag(cdbTag), .cdbData(cdbData)
    );
endmodule

// ==== sim/clockGen.sv ====
/* free-running 20 ns clock, rstN held low through the first 3 rising edges */
`timescale 1ns/10ps
module clockGen (
    output logic clk,
    output logic rstN
);
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        rstN = 1'b0;
        repeat (3) @(posedge clk);
        rstN <= 1'b1;
    end
endmodule

// ==== sim/ramModel.sv ====
/* 128 KB byte memory on address bits 16:0, a read shows its byte one ready cycle later;
   writes with bits 17:16 set are I/O, +0 sends a character and +4 ends the program */
`timescale 1ns/10ps
module ramModel (
    input  logic clk,
    input  logic rstN,
    input  logic rdy,
    input  logic [31:0] addr,
    input  logic wr,
    input  logic [7:0] din,
    output logic [7:0] dout,
    output logic ioValid,
    output logic [7:0] ioByte,
    output logic endSeen
);
    logic [7:0] mem [0:131071];
    logic isIo;

    assign isIo = addr[17:16] == 2'b11;

    // the core keeps its address while frozen, so read data holds as well
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            dout <= 8'h00;
            ioValid <= 1'b0;
            endSeen <= 1'b0;
        end else begin
            if (rdy) begin
                dout <= mem[addr[16:0]];
            end
            ioValid <= wr && isIo && !addr[2];
            if (wr && isIo && addr[2]) begin
                endSeen <= 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        if (wr && isIo) begin
            ioByte <= din;
        end
        if (wr && !isIo) begin
            mem[addr[16:0]] <= din;
        end
    end
endmodule

// ==== sim/cpuTb.sv ====
/* random straight-line program checked against an architectural model of RV32I;
   needs a simulator with timing support, stops at the first mismatch */
`timescale 1ns/10ps
module cpuTb;
    localparam int bodyCount = 80;

    logic clk, rstN, rdy;
    logic [7:0] memDin, memDout, ioByte;
    logic [31:0] memA;
    logic memWr, ioValid, endSeen;
    logic [31:0] lfsr = 32'h13a9_ac14;
    logic [31:0] prog [$];
    logic [31:0] refRegs [32];
    logic [7:0] expIo [$];
    logic [7:0] expBytes [logic [31:0]];
    int cycleLimit;
    int cycleCount = 0;
    int ioIndex = 0;

    clockGen clkGen (.clk(clk), .rstN(rstN));

    ramModel ram (
        .clk(clk), .rstN(rstN), .rdy(rdy), .addr(memA), .wr(memWr), .din(memDout),
        .dout(memDin), .ioValid(ioValid), .ioByte(ioByte), .endSeen(endSeen)
    );

    cpu uut (
        .clk_in(clk), .rstN(rstN), .rdy(rdy), .memDin(memDin), .memDout(memDout),
        .memA(memA), .memWr(memWr)
    );

    // Galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsrNext(logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    task automatic takeBits(input int n, output logic [31:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsrNext(lfsr);
        end
    endtask

    task automatic pickReg(output logic [4:0] r);
        logic [31:0] v;
        // half the picks from x0..x7, so chains and x0 writes are common
        takeBits(1, v);
        if (v[0]) begin
            takeBits(3, v);
        end else begin
            takeBits(5, v);
        end
        r = v[4:0];
    endtask

    // also builds I and S words, the immediate split over the f7 and rs2 or rd fields
    function automatic logic [31:0] encR(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
        logic [2:0] f3, logic [4:0] rd, logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    task automatic genBody();
        logic [31:0] kind, f3, alt, imm;
        logic [4:0] rd, rs1, rs2;
        logic [6:0] f7;
        logic [11:0] immField;
        int sweep;
        for (int n = 0; n < bodyCount; n++) begin
            takeBits(3, kind);
            takeBits(3, f3);
            takeBits(1, alt);
            takeBits(20, imm);
            pickReg(rd);
            pickReg(rs1);
            pickReg(rs2);
            // last 20 sweep every OP and OP-IMM operation into x3..x22
            if (n >= bodyCount - 20) begin
                sweep = n - (bodyCount - 20);
                kind = (sweep < 10) ? 3 : 0;
                f3 = (sweep % 10 < 8) ? sweep % 10 : ((sweep % 10 == 8) ? 0 : 5);
                alt = (sweep % 10 >= 8) ? 1 : 0;
                rd = 5'(sweep + 3);
            end
            f7 = (alt[0] && (f3[2:0] == 3'd0 || f3[2:0] == 3'd5)) ? 7'h20 : 7'h00;
            if (f3[2:0] == 3'd1) begin
                immField = {7'h00, imm[4:0]};
            end else if (f3[2:0] == 3'd5) begin
                immField = {(alt[0] ? 7'h20 : 7'h00), imm[4:0]};
            end else begin
                immField = imm[11:0];
            end
            if (kind == 7) begin
                prog.push_back({imm[19:0], rd, cpuPkg::opLui});
            end else if (kind >= 3) begin
                prog.push_back(encR(f7, rs2, rs1, f3[2:0], rd, cpuPkg::opOp));
            end else begin
                prog.push_back(encR(immField[11:5], immField[4:0], rs1, f3[2:0], rd,
                    cpuPkg::opOpImm));
            end
        end
    endtask

    // register dump at 0x10000, then characters and the end store
    task automatic genTail();
        logic [31:0] sel;
        logic [11:0] off;
        prog.push_back({20'h00010, 5'd1, cpuPkg::opLui});
        for (int r = 0; r < 32; r++) begin
            off = 12'(4 * r);
            prog.push_back(encR(off[11:5], 5'(r), 5'd1, cpuPkg::f3Word, off[4:0],
                cpuPkg::opStore));
        end
        prog.push_back({20'h00030, 5'd2, cpuPkg::opLui});
        repeat (8) begin
            takeBits(5, sel);
            prog.push_back(encR(7'd0, sel[4:0], 5'd2, cpuPkg::f3Byte, 5'd0, cpuPkg::opStore));
        end
        prog.push_back(encR(7'd0, 5'd0, 5'd2, cpuPkg::f3Byte, 5'd4, cpuPkg::opStore));
    endtask

    // result of one OP, OP-IMM or LUI word under the RV32I rules
    function automatic logic [31:0] refAlu(cpuPkg::instWord w, logic [31:0] a,
        logic [31:0] b);
        logic [31:0] rhs, res;
        logic signed [31:0] sra;
        logic [4:0] sh;
        rhs = w.r.opcode == cpuPkg::opOp ? b : {{20{w.i.imm[11]}}, w.i.imm};
        sh = rhs[4:0];
        sra = $signed(a) >>> sh;
        case (w.r.funct3)
            3'd0: res = (w.r.opcode == cpuPkg::opOp && w.r.funct7[5]) ? a - rhs : a + rhs;
            3'd1: res = a << sh;
            3'd2: res = $signed(a) < $signed(rhs) ? 32'd1 : 32'd0;
            3'd3: res = a < rhs ? 32'd1 : 32'd0;
            3'd4: res = a ^ rhs;
            3'd5: res = w.r.funct7[5] ? sra : a >> sh;
            3'd6: res = a | rhs;
            default: res = a & rhs;
        endcase
        if (w.u.opcode == cpuPkg::opLui) begin
            res = {w.u.imm, 12'h000};
        end
        return res;
    endfunction

    task automatic runReference();
        cpuPkg::instWord w;
        logic [31:0] addr, data;
        foreach (refRegs[r]) begin
            refRegs[r] = '0;
        end
        foreach (prog[n]) begin
            w = prog[n];
            if (w.s.opcode == cpuPkg::opStore) begin
                addr = refRegs[w.s.rs1] + {{20{w.s.immHi[6]}}, w.s.immHi, w.s.immLo};
                data = refRegs[w.s.rs2];
                if (addr[17:16] == 2'b11) begin
                    if (!addr[2]) begin
                        expIo.push_back(data[7:0]);
                    end
                end else if (w.s.funct3 == cpuPkg::f3Word) begin
                    for (int k = 0; k < 4; k++) begin
                        expBytes[addr + 32'(k)] = data[8 * k +: 8];
                    end
                end else begin
                    expBytes[addr] = data[7:0];
                end
            end else if (w.r.rd != 5'd0) begin
                refRegs[w.r.rd] = refAlu(w, refRegs[w.r.rs1], refRegs[w.r.rs2]);
            end
        end
    endtask

    task automatic checkValue(string name, logic [31:0] expected, logic [31:0] actual);
        if (expected !== actual) begin
            $display("[ERROR] %s expected %h actual %h", name, expected, actual);
            $display("Test FAILED");
            $fatal(1);
        end
    endtask

    task automatic checkMemory();
        foreach (expBytes[a]) begin
            checkValue($sformatf("dump byte %h", a), {24'h0, expBytes[a]},
                {24'h0, ram.mem[a[16:0]]});
        end
    endtask

    initial begin
        logic [31:0] bits;
        rdy = 1'b0;
        genBody();
        genTail();
        runReference();
        // 40 cycles per instruction, doubled for frozen cycles
        cycleLimit = 80 * prog.size();
        foreach (prog[n]) begin
            for (int k = 0; k < 4; k++) begin
                ram.mem[4 * n + k] = prog[n][8 * k +: 8];
            end
        end
        forever begin
            @(posedge clk);
            takeBits(2, bits);
            // roughly one cycle in four frozen
            rdy <= bits[1:0] != 2'b00;
        end
    end

    always @(posedge clk) begin
        logic [7:0] expected;
        if (rstN) begin
            cycleCount++;
            if (cycleCount > cycleLimit) begin
                $display("no program end within %0d cycles", cycleLimit);
                $display("Test FAILED");
                $fatal(1);
            end
            if (ioValid) begin
                if (expIo.size() == 0) begin
                    $display("an I/O byte arrived after all expected bytes");
                    $display("Test FAILED");
                    $fatal(1);
                end else begin
                    expected = expIo.pop_front();
                    checkValue($sformatf("io byte %0d", ioIndex), {24'h0, expected},
                        {24'h0, ioByte});
                    ioIndex++;
                end
            end
            if (endSeen) begin
                checkMemory();
                if (expIo.size() != 0) begin
                    $display("program ended with %0d I/O bytes missing", expIo.size());
                    $display("Test FAILED");
                    $fatal(1);
                end else begin
                    $display("Test OK");
                    $finish;
                end
            end
        end
    end

    // a frozen core must keep writes off the bus
    always @(negedge clk) begin
        if (rstN && memWr && !rdy) begin
            $display("memWr high at %0t while rdy is low", $time);
            $display("Test FAILED");
            $fatal(1);
        end
    end
endmodule

// ==== build.f ====
verilog/cpuPkg.sv
verilog/memCtrl.sv
verilog/dispatcher.sv
verilog/regFile.sv
verilog/rsEntry.sv
verilog/aluIssue.sv
verilog/cpu.sv
sim/clockGen.sv
sim/ramModel.sv
sim/cpuTb.sv

// ==== run.sh ====
#!/bin/sh
# build the cpuTb simulation with Verilator, run it and scan the log
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/10ps -j 0 --top-module cpuTb -f build.f
./obj_dir/VcpuTb | tee sim.log
if grep -q "Test FAILED" sim.log; then
    echo "simulation failed"
    exit 1
fi
if ! grep -q "Test OK" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"
